//--- logic/rvc_settings.svh
// Fetch front end constants for reset PC, base opcodes, registers and fixed words
`ifndef RVC_SETTINGS_SVH
`define RVC_SETTINGS_SVH

// ==============================
// Fetch start
// ==============================
`define RVC_RESET_PC 32'h0000_1000

// Fixed instruction words
`define RVC_NOP      32'h0000_0013 // ADDI x0, x0, 0
`define RVC_EBREAK   32'h0010_0073

// ==============================
// RV32I base opcodes
// ==============================
`define RVC_OP_IMM   7'b0010011
`define RVC_OP       7'b0110011
`define RVC_LOAD     7'b0000011
`define RVC_STORE    7'b0100011
`define RVC_LUI      7'b0110111
`define RVC_JAL      7'b1101111
`define RVC_JALR     7'b1100111
`define RVC_BRANCH   7'b1100011

// Implicit registers of the compressed forms
`define RVC_REG_SP   5'd2
`define RVC_REG_RA   5'd1

`endif

//--- logic/rvc_pkg.sv
// Compressed instruction format views and the parcel union shared by fetch and expansion
package rvc_pkg;

    // ==============================
    // One struct per RVC format
    // ==============================
    typedef struct packed {
        logic [3:0] funct4;
        logic [4:0] rd_rs1;
        logic [4:0] rs2;
        logic [1:0] op;
    } rvc_cr_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic       imm_hi;    // Bit 12, sign of the immediate
        logic [4:0] rd_rs1;
        logic [4:0] imm_lo;    // Bits 6..2
        logic [1:0] op;
    } rvc_ci_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [5:0] imm;       // Bits 12..7
        logic [4:0] rs2;
        logic [1:0] op;
    } rvc_css_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [7:0] imm;       // Bits 12..5, scrambled nzuimm
        logic [2:0] rd_p;
        logic [1:0] op;
    } rvc_ciw_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] imm_hi;
        logic [2:0] rs1_p;
        logic [1:0] imm_lo;
        logic [2:0] rd_p;
        logic [1:0] op;
    } rvc_cl_t;

    // Same layout as CL, the low register is a source
    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] imm_hi;
        logic [2:0] rs1_p;
        logic [1:0] imm_lo;    // Also funct2 of the ALU group
        logic [2:0] rs2_p;
        logic [1:0] op;
    } rvc_cs_t;

    typedef struct packed {
        logic [2:0] funct3;
        logic [2:0] off_hi;    // Low two bits double as funct2
        logic [2:0] rs1_p;
        logic [4:0] off_lo;
        logic [1:0] op;
    } rvc_cb_t;

    typedef struct packed {
        logic [2:0]  funct3;
        logic [10:0] target;
        logic [1:0]  op;
    } rvc_cj_t;

    // The same 16 bits read through every format
    typedef union packed {
        rvc_cr_t     cr;
        rvc_ci_t     ci;
        rvc_css_t    css;
        rvc_ciw_t    ciw;
        rvc_cl_t     cl;
        rvc_cs_t     cs;
        rvc_cb_t     cb;
        rvc_cj_t     cj;
        logic [15:0] raw;
    } rvc_parcel_t;

endpackage

//--- logic/rvc_expander.sv
// RV32C expander mapping one compressed parcel onto its RV32I word, flags reserved codes
`timescale 1ns/1ps
`include "rvc_settings.svh"

module rvc_expander
    import rvc_pkg::*;
(
    input  rvc_parcel_t parcel,
    input  logic        compressed,
    input  logic [31:0] word_in,
    output logic [31:0] expanded,
    output logic        illegal
);

    // ==============================
    // Register fields
    // ==============================
    logic [4:0]  rd_rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd_p;
    logic [4:0]  rs1_p;
    logic [4:0]  rs2_p;
    logic [2:0]  alu_f3;

    // Immediates, already in RV32I bit order
    logic [11:0] ci_imm;
    logic [11:0] ciw_imm;
    logic [11:0] ls_imm;       // CL and CS share it
    logic [11:0] sp_imm;       // ADDI16SP
    logic [11:0] lwsp_imm;
    logic [11:0] swsp_imm;
    logic [19:0] u_imm;
    logic [12:0] b_imm;
    logic [20:0] j_imm;

    assign rd_rs1 = parcel.ci.rd_rs1;
    assign rs2    = parcel.cr.rs2;
    assign rd_p   = {2'b01, parcel.cl.rd_p};   // x8..x15
    assign rs1_p  = {2'b01, parcel.cl.rs1_p};
    assign rs2_p  = {2'b01, parcel.cs.rs2_p};

    assign ci_imm  = {{6{parcel.ci.imm_hi}}, parcel.ci.imm_hi, parcel.ci.imm_lo};
    assign ciw_imm = {2'b00, parcel.ciw.imm[5:2], parcel.ciw.imm[7:6],
                      parcel.ciw.imm[0], parcel.ciw.imm[1], 2'b00};
    assign ls_imm  = {5'b0, parcel.cl.imm_lo[0], parcel.cl.imm_hi, parcel.cl.imm_lo[1], 2'b00};
    assign sp_imm  = {{2{parcel.ci.imm_hi}}, parcel.ci.imm_hi, parcel.ci.imm_lo[2:1],
                      parcel.ci.imm_lo[3], parcel.ci.imm_lo[0], parcel.ci.imm_lo[4], 4'b0000};
    assign lwsp_imm = {4'b0, parcel.ci.imm_lo[1:0], parcel.ci.imm_hi,
                       parcel.ci.imm_lo[4:2], 2'b00};
    assign swsp_imm = {4'b0, parcel.css.imm[1:0], parcel.css.imm[5:2], 2'b00};
    assign u_imm   = {{14{parcel.ci.imm_hi}}, parcel.ci.imm_hi, parcel.ci.imm_lo};
    assign b_imm   = {{4{parcel.cb.off_hi[2]}}, parcel.cb.off_hi[2], parcel.cb.off_lo[4:3],
                      parcel.cb.off_lo[0], parcel.cb.off_hi[1:0], parcel.cb.off_lo[2:1], 1'b0};
    assign j_imm   = {{9{parcel.cj.target[10]}}, parcel.cj.target[10], parcel.cj.target[6],
                      parcel.cj.target[8:7], parcel.cj.target[4], parcel.cj.target[5],
                      parcel.cj.target[0], parcel.cj.target[9], parcel.cj.target[3:1], 1'b0};

    // SUB, XOR, OR, AND
    always_comb begin
        case (parcel.cs.imm_lo)
            2'b00:   alu_f3 = 3'b000;
            2'b01:   alu_f3 = 3'b100;
            2'b10:   alu_f3 = 3'b110;
            default: alu_f3 = 3'b111;
        endcase
    end

    // ==============================
    // Decode by quadrant and funct3
    // ==============================
    always_comb begin
        expanded = word_in;    // 32-bit words pass through
        illegal  = 1'b0;
        if (compressed) begin
            expanded = `RVC_NOP;
            case ({parcel.cr.op, parcel.ci.funct3})
                5'b00_000: begin   // C.ADDI4SPN
                    illegal  = (parcel.ciw.imm == 8'd0);
                    expanded = {ciw_imm, `RVC_REG_SP, 3'b000, rd_p, `RVC_OP_IMM};
                end
                5'b00_010: expanded = {ls_imm, rs1_p, 3'b010, rd_p, `RVC_LOAD};
                5'b00_110: expanded = {ls_imm[11:5], rs2_p, rs1_p, 3'b010, ls_imm[4:0], `RVC_STORE};
                // C.ADDI, C.NOP is the all-zero case
                5'b01_000: expanded = {ci_imm, rd_rs1, 3'b000, rd_rs1, `RVC_OP_IMM};
                5'b01_001: expanded = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12],
                                       `RVC_REG_RA, `RVC_JAL};
                5'b01_010: expanded = {ci_imm, 5'd0, 3'b000, rd_rs1, `RVC_OP_IMM};
                5'b01_011: begin
                    illegal = ({parcel.ci.imm_hi, parcel.ci.imm_lo} == 6'd0);
                    if (rd_rs1 == `RVC_REG_SP) begin
                        expanded = {sp_imm, `RVC_REG_SP, 3'b000, `RVC_REG_SP, `RVC_OP_IMM};
                    end else begin
                        expanded = {u_imm, rd_rs1, `RVC_LUI};
                    end
                end
                5'b01_100: begin
                    case (parcel.cb.off_hi[1:0])
                        2'b00: begin   // C.SRLI, shamt[5] reserved on RV32
                            illegal  = parcel.ci.imm_hi;
                            expanded = {7'b0, parcel.ci.imm_lo, rs1_p, 3'b101, rs1_p, `RVC_OP_IMM};
                        end
                        2'b01: begin   // C.SRAI
                            illegal  = parcel.ci.imm_hi;
                            expanded = {7'b0100000, parcel.ci.imm_lo, rs1_p, 3'b101, rs1_p,
                                        `RVC_OP_IMM};
                        end
                        2'b10: expanded = {ci_imm, rs1_p, 3'b111, rs1_p, `RVC_OP_IMM};
                        default: begin
                            illegal  = parcel.ci.imm_hi;   // SUBW and ADDW are RV64 only
                            expanded = {(parcel.cs.imm_lo == 2'b00) ? 7'b0100000 : 7'b0,
                                        rs2_p, rs1_p, alu_f3, rs1_p, `RVC_OP};
                        end
                    endcase
                end
                5'b01_101: expanded = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12],
                                       5'd0, `RVC_JAL};
                5'b01_110,
                5'b01_111: expanded = {b_imm[12], b_imm[10:5], 5'd0, rs1_p,
                                       {2'b00, parcel.ci.funct3[0]}, b_imm[4:1], b_imm[11],
                                       `RVC_BRANCH};
                5'b10_000: begin   // C.SLLI
                    illegal  = parcel.ci.imm_hi;
                    expanded = {7'b0, parcel.ci.imm_lo, rd_rs1, 3'b001, rd_rs1, `RVC_OP_IMM};
                end
                5'b10_010: begin   // C.LWSP needs a real destination
                    illegal  = (rd_rs1 == 5'd0);
                    expanded = {lwsp_imm, `RVC_REG_SP, 3'b010, rd_rs1, `RVC_LOAD};
                end
                5'b10_100: begin
                    if (!parcel.cr.funct4[0]) begin
                        if (rs2 == 5'd0) begin   // C.JR
                            illegal  = (rd_rs1 == 5'd0);
                            expanded = {12'b0, rd_rs1, 3'b000, 5'd0, `RVC_JALR};
                        end else begin           // C.MV
                            expanded = {7'b0, rs2, 5'd0, 3'b000, rd_rs1, `RVC_OP};
                        end
                    end else if (rs2 == 5'd0 && rd_rs1 == 5'd0) begin
                        expanded = `RVC_EBREAK;
                    end else if (rs2 == 5'd0) begin   // C.JALR
                        expanded = {12'b0, rd_rs1, 3'b000, `RVC_REG_RA, `RVC_JALR};
                    end else begin                    // C.ADD
                        expanded = {7'b0, rs2, rd_rs1, 3'b000, rd_rs1, `RVC_OP};
                    end
                end
                5'b10_110: expanded = {swsp_imm[11:5], rs2, `RVC_REG_SP, 3'b010,
                                       swsp_imm[4:0], `RVC_STORE};
                default:   illegal = 1'b1;   // FP forms and reserved slots
            endcase
            if (illegal) begin
                expanded = `RVC_NOP;
            end
        end
    end

endmodule

//--- logic/parcel_aligner.sv
// Fetch stage that reads memory words and lines up 16-bit parcels into raw instructions
`timescale 1ns/1ps
`include "rvc_settings.svh"

module parcel_aligner
    import rvc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] mem_addr,
    output logic        mem_req,
    input  logic [31:0] mem_data,
    input  logic        mem_ready,
    output logic [31:0] raw_instr,
    output logic [31:0] raw_pc,
    output logic        raw_compressed,
    output logic        raw_valid
);

    rvc_parcel_t lower_p;
    rvc_parcel_t upper_p;
    rvc_parcel_t held_p;         // Spare parcel from the last word
    logic        held_valid;
    logic [31:0] fetch_addr;
    logic [31:0] pc;
    logic        lower_c;
    logic        held_c;
    logic        emit_c;         // Instruction going out is 16 bits
    logic        consume;        // Memory word used up this cycle
    logic [31:0] emit_word;

    assign lower_p.raw = mem_data[15:0];
    assign upper_p.raw = mem_data[31:16];

    assign lower_c = (lower_p.raw[1:0] != 2'b11);
    assign held_c  = (held_p.raw[1:0] != 2'b11);
    assign emit_c  = held_valid ? held_c : lower_c;
    assign consume = !(held_valid && held_c);   // A held RVC parcel leaves the word alone

    assign mem_addr = fetch_addr;
    assign mem_req  = rst_n;

    // ==============================
    // Alignment cases
    // ==============================
    always_comb begin
        if (!held_valid) begin
            emit_word = lower_c ? {16'h0000, lower_p.raw} : mem_data;
        end else if (held_c) begin
            emit_word = {16'h0000, held_p.raw};
        end else begin
            emit_word = {lower_p.raw, held_p.raw};   // Straddles the word boundary
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_addr     <= `RVC_RESET_PC;
            pc             <= `RVC_RESET_PC;
            held_valid     <= 1'b0;
            raw_compressed <= 1'b0;
            raw_valid      <= 1'b0;
        end else begin
            raw_valid <= mem_ready;
            if (mem_ready) begin
                raw_compressed <= emit_c;
                pc             <= pc + (emit_c ? 32'd2 : 32'd4);
                held_valid     <= held_valid ? !held_c : lower_c;
                if (consume) begin
                    fetch_addr <= fetch_addr + 32'd4;
                end
            end
        end
    end

    // Payload follows the strobe
    always_ff @(posedge clk) begin
        if (mem_ready) begin
            raw_instr <= emit_word;
            raw_pc    <= pc;
            if (consume) begin
                held_p <= upper_p;
            end
        end
    end

endmodule

//--- logic/expand_stage.sv
// Second pipeline stage that expands each aligned instruction and registers the result
`timescale 1ns/1ps
`include "rvc_settings.svh"

module expand_stage
    import rvc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] raw_instr,
    input  logic [31:0] raw_pc,
    input  logic        raw_compressed,
    input  logic        raw_valid,
    output logic [31:0] instr,
    output logic [31:0] instr_pc,
    output logic        instr_valid,
    output logic        instr_compressed,
    output logic        instr_illegal
);

    rvc_parcel_t parcel;
    logic [31:0] expanded;
    logic        illegal;

    assign parcel.raw = raw_instr[15:0];   // RVC parcel sits low

    rvc_expander u_expander (
        .parcel     (parcel),
        .compressed (raw_compressed),
        .word_in    (raw_instr),
        .expanded   (expanded),
        .illegal    (illegal)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr            <= `RVC_NOP;
            instr_valid      <= 1'b0;
            instr_compressed <= 1'b0;
            instr_illegal    <= 1'b0;
        end else begin
            instr_valid <= raw_valid;   // Drops on idle cycles
            if (raw_valid) begin
                instr            <= expanded;
                instr_compressed <= raw_compressed;
                instr_illegal    <= illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (raw_valid) begin
            instr_pc <= raw_pc;
        end
    end

endmodule

//--- logic/rvc_fetch_top.sv
// Fetch front end top joining the parcel aligner and the expansion stage
`timescale 1ns/1ps

module rvc_fetch_top (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] mem_addr,
    output logic        mem_req,
    input  logic [31:0] mem_data,
    input  logic        mem_ready,
    output logic [31:0] instr,
    output logic [31:0] instr_pc,
    output logic        instr_valid,
    output logic        instr_compressed,
    output logic        instr_illegal
);

    // Aligner to expander
    logic [31:0] raw_instr;
    logic [31:0] raw_pc;
    logic        raw_compressed;
    logic        raw_valid;

    parcel_aligner u_aligner (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_addr       (mem_addr),
        .mem_req        (mem_req),
        .mem_data       (mem_data),
        .mem_ready      (mem_ready),
        .raw_instr      (raw_instr),
        .raw_pc         (raw_pc),
        .raw_compressed (raw_compressed),
        .raw_valid      (raw_valid)
    );

    expand_stage u_expand (
        .clk              (clk),
        .rst_n            (rst_n),
        .raw_instr        (raw_instr),
        .raw_pc           (raw_pc),
        .raw_compressed   (raw_compressed),
        .raw_valid        (raw_valid),
        .instr            (instr),
        .instr_pc         (instr_pc),
        .instr_valid      (instr_valid),
        .instr_compressed (instr_compressed),
        .instr_illegal    (instr_illegal)
    );

endmodule

//--- sim/rvc_checker.sv
// Output monitor that compares each fetched instruction with the expected stream
`timescale 1ns/1ps
`include "rvc_settings.svh"

module rvc_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] mem_addr,
    input  logic        mem_req,
    input  logic [31:0] instr,
    input  logic [31:0] instr_pc,
    input  logic        instr_valid,
    input  logic        instr_compressed,
    input  logic        instr_illegal,
    output int          seen_count,
    output int          value_errors,
    output int          stream_errors
);

    localparam int MAX_TESTS = 64;
    localparam int NAME_W    = 8 * 24;

    logic [NAME_W-1:0] exp_name  [0:MAX_TESTS-1];
    logic [31:0]       exp_pc    [0:MAX_TESTS-1];
    logic [31:0]       exp_instr [0:MAX_TESTS-1];
    logic              exp_c     [0:MAX_TESTS-1];
    logic              exp_ill   [0:MAX_TESTS-1];
    int                n_expect = 0;
    logic              was_reset;     // Last sampled cycle was in reset

    initial begin
        seen_count    = 0;
        value_errors  = 0;
        stream_errors = 0;
        was_reset     = 1'b0;
    end

    // Appends one entry to the expected stream
    task automatic push_expect(input logic [NAME_W-1:0] name, input logic [31:0] pc,
                               input logic [31:0] word, input logic c, input logic ill);
        if (n_expect < MAX_TESTS) begin
            exp_name[n_expect]  = name;
            exp_pc[n_expect]    = pc;
            exp_instr[n_expect] = word;
            exp_c[n_expect]     = c;
            exp_ill[n_expect]   = ill;
            n_expect++;
        end
    endtask

    task automatic compare_field(input logic [NAME_W-1:0] name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("Error %0s %0s expected %h actual %h", name, field, expected, actual);
        end
    endtask

    // ==============================
    // Sampled mid-cycle
    // ==============================
    always @(negedge clk) begin
        if (mem_req !== rst_n) begin      // Request tracks reset release
            stream_errors++;
            $display("Memory request is %b while reset input is %b", mem_req, rst_n);
        end
        if (!rst_n || was_reset) begin    // Reset and the first cycle after it
            if (instr_valid !== 1'b0 || instr_compressed !== 1'b0 || instr_illegal !== 1'b0
                || mem_addr !== `RVC_RESET_PC || instr !== `RVC_NOP) begin
                stream_errors++;
                $display("Reset state wrong: valid %b, mem_addr %h, instr %h",
                         instr_valid, mem_addr, instr);
            end
        end
        was_reset = !rst_n;
        if (rst_n && instr_valid) begin
            if (seen_count >= n_expect) begin
                stream_errors++;
                $display("Extra instruction %h at pc %h after the expected stream ended",
                         instr, instr_pc);
            end else begin
                compare_field(exp_name[seen_count], "instr", exp_instr[seen_count], instr);
                compare_field(exp_name[seen_count], "pc", exp_pc[seen_count], instr_pc);
                compare_field(exp_name[seen_count], "compressed",
                              {31'd0, exp_c[seen_count]}, {31'd0, instr_compressed});
                compare_field(exp_name[seen_count], "illegal",
                              {31'd0, exp_ill[seen_count]}, {31'd0, instr_illegal});
                seen_count++;
            end
        end
    end

endmodule

//--- sim/tb_rvc_fetch.sv
// Testbench for the fetch front end driven by a memory image and expected stream from a file
`timescale 1ns/1ps
`include "rvc_settings.svh"

module tb_rvc_fetch;

    localparam int DEPTH  = 64;           // Words in the program image
    localparam int NAME_W = 8 * 24;

    logic        clk;
    logic        rst_n;
    logic [31:0] mem_addr;
    logic        mem_req;
    logic [31:0] mem_data;
    logic        mem_ready;
    logic [31:0] instr;
    logic [31:0] instr_pc;
    logic        instr_valid;
    logic        instr_compressed;
    logic        instr_illegal;

    logic [31:0] image [0:DEPTH-1];
    logic [31:0] mem_offset;
    logic [31:0] end_addr;                // First address past the image
    int          n_tests;
    int          seen_count;
    int          value_errors;
    int          stream_errors;
    int          seed_val;

    rvc_fetch_top dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .mem_addr         (mem_addr),
        .mem_req          (mem_req),
        .mem_data         (mem_data),
        .mem_ready        (mem_ready),
        .instr            (instr),
        .instr_pc         (instr_pc),
        .instr_valid      (instr_valid),
        .instr_compressed (instr_compressed),
        .instr_illegal    (instr_illegal)
    );

    rvc_checker chk0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .mem_addr         (mem_addr),
        .mem_req          (mem_req),
        .instr            (instr),
        .instr_pc         (instr_pc),
        .instr_valid      (instr_valid),
        .instr_compressed (instr_compressed),
        .instr_illegal    (instr_illegal),
        .seen_count       (seen_count),
        .value_errors     (value_errors),
        .stream_errors    (stream_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Memory model
    // ==============================
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hA5C3_5A3C;
    endfunction

    assign mem_offset = mem_addr - `RVC_RESET_PC;

    always_comb begin
        if (mem_offset[31:8] == 24'd0) begin
            mem_data = image[mem_offset[7:2]];
        end else begin
            mem_data = fill_word(mem_addr);   // Outside the image
        end
    end

    task automatic print_counts();
        $display("Errors: %0d value, %0d stream, %0d of %0d instructions checked",
                 value_errors, stream_errors, seen_count, n_tests);
    endtask

    task automatic stop_with_failure(input string reason);
        $display("%0s", reason);
        print_counts();
        $display("Test failed");
        $finish;
    endtask

    task automatic load_tests();
        int                fd;
        int                code;
        int                c_flag;
        int                i_flag;
        logic [7:0]        tag;
        logic [8*128-1:0]  line;
        logic [NAME_W-1:0] name;
        logic [31:0]       addr;
        logic [31:0]       word;
        logic [31:0]       offset;
        for (int k = 0; k < DEPTH; k++) begin
            image[k] = fill_word(`RVC_RESET_PC + 4 * k);
        end
        fd = $fopen("sim/rvc_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open sim/rvc_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code == 1) begin
                    if (tag == "#") begin
                        code = $fgets(line, fd);       // Skip comment text
                    end else if (tag == "m") begin
                        code = $fscanf(fd, "%h %h", addr, word);
                        offset = addr - `RVC_RESET_PC;
                        image[offset[7:2]] = word;
                        if (addr + 32'd4 > end_addr) begin
                            end_addr = addr + 32'd4;
                        end
                    end else if (tag == "e") begin
                        code = $fscanf(fd, "%s %h %h %d %d", name, addr, word, c_flag, i_flag);
                        chk0.push_expect(name, addr, word, c_flag[0], i_flag[0]);
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ==============================
    // Stimulus and final report
    // ==============================
    initial begin
        rst_n     = 1'b0;
        mem_ready = 1'b0;
        n_tests   = 0;
        end_addr  = `RVC_RESET_PC;
        seed_val  = $urandom(3);
        load_tests();
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        while (seen_count < n_tests) begin
            @(posedge clk);
            #2 mem_ready = ($urandom % 10 < 7) && (mem_addr < end_addr);   // About 70 %
        end
        mem_ready = 1'b0;
        repeat (6) @(posedge clk);   // Catch stray pulses
        print_counts();
        if (value_errors == 0 && stream_errors == 0 && n_tests > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Limit scales with the number of expected instructions
    initial begin
        #1;
        repeat (n_tests * 4 + 50) @(posedge clk);
        stop_with_failure("Watchdog expired before all expected instructions arrived");
    end

endmodule

//--- sim/rvc_tests.txt
# m <word address> <word>   e <name> <pc> <expected instr> <compressed> <illegal>
# Addresses and words in hex, flags are 0 or 1
m 00001000 00500093
m 00001004 002081b3
m 00001008 41440800
m 0000100c 10fd0001
m 00001010 62852021
m 00001014 dd758c05
m 00001018 900240b2
m 0000101c 2203852e
m 00001020 ca0e0101
m 00001024 62810000
m 00001028 20004012
m 0000102c 123453b7
e addi_word    00001000 00500093 0 0
e add_word     00001004 002081b3 0 0
e c_addi4spn   00001008 01010413 1 0
e c_lw         0000100a 00452483 1 0
e c_nop        0000100c 00000013 1 0
e c_addi       0000100e fff08093 1 0
e c_jal        00001010 008000ef 1 0
e c_lui        00001012 000012b7 1 0
e c_sub        00001014 40940433 1 0
e c_beqz       00001016 fe050ee3 1 0
e c_lwsp       00001018 00c12083 1 0
e c_ebreak     0000101a 00100073 1 0
e c_mv         0000101c 00b00533 1 0
e lw_straddle  0000101e 01012203 0 0
e c_swsp       00001022 00312a23 1 0
e bad_addi4spn 00001024 00000013 1 1
e bad_lui      00001026 00000013 1 1
e bad_lwsp     00001028 00000013 1 1
e bad_fld      0000102a 00000013 1 1
e lui_word     0000102c 123453b7 0 0

//--- tb.f
+incdir+logic
logic/rvc_pkg.sv
logic/rvc_expander.sv
logic/parcel_aligner.sv
logic/expand_stage.sv
logic/rvc_fetch_top.sv
sim/rvc_checker.sv
sim/tb_rvc_fetch.sv

//--- Bender.yml
package:
  name: rvc_fetch

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/rvc_pkg.sv
      - logic/rvc_expander.sv
      - logic/parcel_aligner.sv
      - logic/expand_stage.sv
      - logic/rvc_fetch_top.sv
      - target: simulation
        files:
          - sim/rvc_checker.sv
          - sim/tb_rvc_fetch.sv
